/* flist.f */
+incdir+sim
rtl/hazard_pkg.sv
rtl/operand_role_decode.sv
rtl/fwd_path_compare.sv
rtl/load_use_detect.sv
rtl/hazard_unit.sv
sim/tb_hazard_unit.sv

/* Bender.yml */
package:
  name: hazard_unit

sources:
  - rtl/hazard_pkg.sv
  - rtl/operand_role_decode.sv
  - rtl/fwd_path_compare.sv
  - rtl/load_use_detect.sv
  - rtl/hazard_unit.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_hazard_unit.sv

/* sim/hazard_model.svh */
`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

// Register roles of one stage, straight from the opcode rules
function automatic hazard_pkg::reg_role_t model_role(input hazard_pkg::stage_info_t s);
    hazard_pkg::reg_role_t r;
    logic st;
    st = (s.opcode == hazard_pkg::op_st);
    r.reads_src1 = !(s.opcode inside {hazard_pkg::op_nop, hazard_pkg::op_b, hazard_pkg::op_beq,
        hazard_pkg::op_bgt, hazard_pkg::op_call, hazard_pkg::op_not, hazard_pkg::op_mov});
    r.src1 = (s.opcode == hazard_pkg::op_ret) ? hazard_pkg::ra_index : s.rs1;
    r.reads_src2 = !(s.opcode inside {hazard_pkg::op_nop, hazard_pkg::op_b, hazard_pkg::op_beq,
        hazard_pkg::op_bgt, hazard_pkg::op_call}) && (st || !s.imm_bit);
    r.src2 = st ? s.rd : s.op2.regs.rs2;
    r.writes_dest = !(s.opcode inside {hazard_pkg::op_nop, hazard_pkg::op_cmp, hazard_pkg::op_st,
        hazard_pkg::op_b, hazard_pkg::op_beq, hazard_pkg::op_bgt, hazard_pkg::op_ret});
    r.dest = (s.opcode == hazard_pkg::op_call) ? hazard_pkg::ra_index : s.rd;
    r.is_load = (s.opcode == hazard_pkg::op_ld);
    return r;
endfunction

// Flags expected one cycle after the stages are sampled
function automatic hazard_pkg::fwd_flags_t model_flags(input hazard_pkg::stage_info_t dd,
    input hazard_pkg::stage_info_t ex, input hazard_pkg::stage_info_t mem,
    input hazard_pkg::stage_info_t wb);
    hazard_pkg::fwd_flags_t f;
    hazard_pkg::reg_role_t rd_dd;
    hazard_pkg::reg_role_t rd_ex;
    hazard_pkg::reg_role_t rd_mem;
    hazard_pkg::reg_role_t rd_wb;
    logic wb_w;
    logic mem_w;
    logic dep;
    rd_dd = model_role(dd);
    rd_ex = model_role(ex);
    rd_mem = model_role(mem);
    rd_wb = model_role(wb);
    wb_w = wb.valid && rd_wb.writes_dest;
    mem_w = mem.valid && rd_mem.writes_dest && !rd_mem.is_load;
    f.wb_dd_rs1 = wb_w && dd.valid && rd_dd.reads_src1 && rd_dd.src1 == rd_wb.dest;
    f.wb_dd_rs2 = wb_w && dd.valid && rd_dd.reads_src2 && rd_dd.src2 == rd_wb.dest;
    f.mem_exec_rs1 = mem_w && ex.valid && rd_ex.reads_src1 && rd_ex.src1 == rd_mem.dest;
    f.mem_exec_rs2 = mem_w && ex.valid && rd_ex.reads_src2 && rd_ex.src2 == rd_mem.dest;
    f.wb_exec_rs1 = wb_w && ex.valid && rd_ex.reads_src1 && rd_ex.src1 == rd_wb.dest;
    f.wb_exec_rs2 = wb_w && ex.valid && rd_ex.reads_src2 && rd_ex.src2 == rd_wb.dest;
    f.wb_mem_rs1 = wb_w && mem.valid && rd_mem.reads_src1 && rd_mem.src1 == rd_wb.dest;
    f.wb_mem_rs2 = wb_w && mem.valid && rd_mem.reads_src2 && rd_mem.src2 == rd_wb.dest;
    dep = (rd_dd.reads_src1 && rd_dd.src1 != 0 && rd_dd.src1 == rd_ex.dest)
          || (rd_dd.reads_src2 && rd_dd.src2 != 0 && rd_dd.src2 == rd_ex.dest);
    f.ld_use = ex.valid && dd.valid && rd_ex.is_load && dd.opcode != hazard_pkg::op_st
               && rd_ex.dest != 0 && dep;
    return f;
endfunction

`endif

/* sim/tb_hazard_unit.sv */
module tb_hazard_unit;

    timeunit 1ns;
    timeprecision 100ps;

    `include "hazard_model.svh"

    // Whole run must end well before this
    localparam int watchdog_ns = 10000;

    logic                    clk = 1'b0;
    logic                    rst_n;
    hazard_pkg::stage_info_t dd_stage;
    hazard_pkg::stage_info_t exec_stage;
    hazard_pkg::stage_info_t mem_stage;
    hazard_pkg::stage_info_t wb_stage;
    hazard_pkg::fwd_flags_t  flags;
    int                      errors;
    int                      timeouts;
    // Flags predicted for the cycle before the one being driven
    hazard_pkg::fwd_flags_t  held_flags;

    hazard_unit dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .dd_stage   (dd_stage),
        .exec_stage (exec_stage),
        .mem_stage  (mem_stage),
        .wb_stage   (wb_stage),
        .flags      (flags)
    );

    initial
    begin
        forever
            #2 clk = ~clk;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Run did not finish within %0d ns, stopped by the watchdog", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Field names with the msb of the flag struct first
    function automatic string field_name(input int i);
        case (i)
            0: return "wb_dd_rs1";
            1: return "wb_dd_rs2";
            2: return "mem_exec_rs1";
            3: return "mem_exec_rs2";
            4: return "wb_exec_rs1";
            5: return "wb_exec_rs2";
            6: return "wb_mem_rs1";
            7: return "wb_mem_rs2";
            default: return "ld_use";
        endcase
    endfunction

    function automatic hazard_pkg::stage_info_t mk_stage(input logic valid,
        input hazard_pkg::opcode_e op, input logic imm_bit, input logic [3:0] rd,
        input logic [3:0] rs1, input logic [17:0] op2);
        hazard_pkg::stage_info_t s;
        s.valid = valid;
        s.opcode = op;
        s.imm_bit = imm_bit;
        s.rd = rd;
        s.rs1 = rs1;
        // rs2 sits in the low bits of op2
        s.op2.imm = op2;
        return s;
    endfunction

    function automatic hazard_pkg::stage_info_t idle_stage();
        return mk_stage(1'b0, hazard_pkg::op_nop, 1'b0, 4'd0, 4'd0, 18'd0);
    endfunction

    // Small register set including ra so random stages collide often
    function automatic logic [3:0] rand_reg();
        int pick;
        pick = $urandom % 5;
        return (pick == 4) ? hazard_pkg::ra_index : 4'(pick);
    endfunction

    function automatic hazard_pkg::stage_info_t rand_stage();
        logic [17:0] op2;
        op2 = 18'($urandom);
        op2[3:0] = rand_reg();
        return mk_stage(($urandom % 4) != 0, hazard_pkg::opcode_e'($urandom % 21),
                        1'($urandom % 2), rand_reg(), rand_reg(), op2);
    endfunction

    // Next falling edge within a few clock changes
    task automatic wait_fall();
        int  tries;
        logic seen;
        tries = 0;
        seen = 1'b0;
        while (!seen && tries < 4)
        begin
            @(clk);
            tries++;
            if (clk == 1'b0)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("Timed out waiting for a falling clock edge at %0t", $time);
            timeouts++;
        end
    endtask

    task automatic check_flags(input hazard_pkg::fwd_flags_t want);
        for (int i = 0; i < 9; i++)
        begin
            if (flags[8-i] !== want[8-i])
            begin
                $display("** Error at %0t: flags.%s is %b, expected %b",
                         $time, field_name(i), flags[8-i], want[8-i]);
                errors++;
            end
        end
    endtask

    // Drive on a falling edge and check one full cycle later
    task automatic run_cycle(input hazard_pkg::stage_info_t dd,
        input hazard_pkg::stage_info_t ex, input hazard_pkg::stage_info_t mem,
        input hazard_pkg::stage_info_t wb, input logic has_want,
        input hazard_pkg::fwd_flags_t want);
        hazard_pkg::fwd_flags_t predicted;
        predicted = model_flags(dd, ex, mem, wb);
        dd_stage = dd;
        exec_stage = ex;
        mem_stage = mem;
        wb_stage = wb;
        // New stages must not reach flags before the rising edge
        #1;
        check_flags(held_flags);
        wait_fall();
        check_flags(predicted);
        if (has_want && flags !== want)
        begin
            $display("** Error at %0t: flags are %b, directed case expects %b",
                     $time, flags, want);
            errors++;
        end
        held_flags = predicted;
    endtask

    // Path 0 wb->dd, 1 mem->exec, 2 wb->exec, 3 wb->mem
    task automatic path_case(input int p, input hazard_pkg::stage_info_t reader,
        input hazard_pkg::stage_info_t writer, input logic w1, input logic w2);
        hazard_pkg::stage_info_t s[4];
        hazard_pkg::fwd_flags_t  want;
        for (int i = 0; i < 4; i++)
            s[i] = idle_stage();
        case (p)
            0:
            begin
                s[0] = reader;
                s[3] = writer;
            end
            1:
            begin
                s[1] = reader;
                s[2] = writer;
            end
            2:
            begin
                s[1] = reader;
                s[3] = writer;
            end
            default:
            begin
                s[2] = reader;
                s[3] = writer;
            end
        endcase
        want = '0;
        want[8-2*p] = w1;
        want[7-2*p] = w2;
        run_cycle(s[0], s[1], s[2], s[3], 1'b1, want);
    endtask

    task automatic reset_checks();
        hazard_pkg::stage_info_t dead;
        // Flags held low for the whole reset
        for (int i = 0; i < 10; i++)
        begin
            wait_fall();
            check_flags('0);
        end
        rst_n = 1'b1;
        run_cycle(idle_stage(), idle_stage(), idle_stage(), idle_stage(), 1'b1, '0);
        // Matching registers but nothing valid
        dead = mk_stage(1'b0, hazard_pkg::op_add, 1'b0, 4'd5, 4'd5, 18'd5);
        run_cycle(dead, dead, dead, dead, 1'b1, '0);
    endtask

    task automatic add_path_tests();
        hazard_pkg::stage_info_t w;
        w = mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd5, 4'd1, 18'd2);
        for (int p = 0; p < 4; p++)
        begin
            path_case(p, mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd5, 18'd7), w, 1, 0);
            path_case(p, mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd3, 18'd5), w, 0, 1);
            path_case(p, mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd3, 18'd7), w, 0, 0);
        end
    endtask

    task automatic special_op_tests();
        hazard_pkg::opcode_e     quiet_ops[5];
        hazard_pkg::stage_info_t w;
        quiet_ops = '{hazard_pkg::op_cmp, hazard_pkg::op_st, hazard_pkg::op_beq,
                      hazard_pkg::op_bgt, hazard_pkg::op_b};
        w = mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd5, 4'd1, 18'd2);
        for (int p = 0; p < 4; p++)
        begin
            // Call writes ra and ret reads it
            path_case(p, mk_stage(1'b1, hazard_pkg::op_ret, 1'b0, 4'd0, 4'd3, 18'd2),
                      mk_stage(1'b1, hazard_pkg::op_call, 1'b0, 4'd4, 4'd0, 18'd0), 1, 0);
            foreach (quiet_ops[k])
                path_case(p, mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd5, 18'd5),
                          mk_stage(1'b1, quiet_ops[k], 1'b0, 4'd5, 4'd5, 18'd5), 0, 0);
            path_case(p, mk_stage(1'b1, hazard_pkg::op_not, 1'b0, 4'd9, 4'd5, 18'd6), w, 0, 0);
            path_case(p, mk_stage(1'b1, hazard_pkg::op_mov, 1'b0, 4'd9, 4'd5, 18'd6), w, 0, 0);
        end
    endtask

    task automatic immediate_tests();
        hazard_pkg::stage_info_t w;
        w = mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd5, 4'd1, 18'd2);
        for (int p = 0; p < 4; p++)
        begin
            // Immediate equal to the dest is no register
            path_case(p, mk_stage(1'b1, hazard_pkg::op_add, 1'b1, 4'd9, 4'd3, 18'd5), w, 0, 0);
            path_case(p, mk_stage(1'b1, hazard_pkg::op_st, 1'b1, 4'd5, 4'd3, 18'd7), w, 0, 1);
            path_case(p, mk_stage(1'b1, hazard_pkg::op_st, 1'b0, 4'd5, 4'd3, 18'd7), w, 0, 1);
        end
    endtask

    task automatic load_tests();
        hazard_pkg::fwd_flags_t want;
        for (int p = 0; p < 4; p++)
            path_case(p, mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd6, 18'd1),
                      mk_stage(1'b1, hazard_pkg::op_ld, 1'b0, 4'd6, 4'd2, 18'd0), p != 1, 0);
        // Load in wb feeds execute and a store in memory
        want = '0;
        want.wb_exec_rs1 = 1'b1;
        want.wb_mem_rs2 = 1'b1;
        run_cycle(idle_stage(), mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd6, 18'd1),
                  mk_stage(1'b1, hazard_pkg::op_st, 1'b0, 4'd6, 4'd2, 18'd0),
                  mk_stage(1'b1, hazard_pkg::op_ld, 1'b0, 4'd6, 4'd2, 18'd0), 1'b1, want);
        want = '0;
        want.ld_use = 1'b1;
        run_cycle(mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd4, 18'd1),
                  mk_stage(1'b1, hazard_pkg::op_ld, 1'b0, 4'd4, 4'd2, 18'd0),
                  idle_stage(), idle_stage(), 1'b1, want);
        run_cycle(mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd1, 18'd4),
                  mk_stage(1'b1, hazard_pkg::op_ld, 1'b0, 4'd4, 4'd2, 18'd0),
                  idle_stage(), idle_stage(), 1'b1, want);
        // Store in decode and load into r0 never stall
        run_cycle(mk_stage(1'b1, hazard_pkg::op_st, 1'b0, 4'd4, 4'd4, 18'd0),
                  mk_stage(1'b1, hazard_pkg::op_ld, 1'b0, 4'd4, 4'd2, 18'd0),
                  idle_stage(), idle_stage(), 1'b1, '0);
        run_cycle(mk_stage(1'b1, hazard_pkg::op_add, 1'b0, 4'd9, 4'd0, 18'd0),
                  mk_stage(1'b1, hazard_pkg::op_ld, 1'b0, 4'd0, 4'd2, 18'd0),
                  idle_stage(), idle_stage(), 1'b1, '0);
    endtask

    task automatic random_tests();
        for (int i = 0; i < 200; i++)
            run_cycle(rand_stage(), rand_stage(), rand_stage(), rand_stage(), 1'b0, '0);
    endtask

    initial
    begin
        void'($urandom(91));
        errors = 0;
        timeouts = 0;
        held_flags = '0;
        rst_n = 1'b0;
        dd_stage = idle_stage();
        exec_stage = idle_stage();
        mem_stage = idle_stage();
        wb_stage = idle_stage();
        reset_checks();
        add_path_tests();
        special_op_tests();
        immediate_tests();
        load_tests();
        random_tests();
        $display("Hazard unit run done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* rtl/hazard_unit.sv */
module hazard_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  hazard_pkg::stage_info_t dd_stage,
    input  hazard_pkg::stage_info_t exec_stage,
    input  hazard_pkg::stage_info_t mem_stage,
    input  hazard_pkg::stage_info_t wb_stage,
    output hazard_pkg::fwd_flags_t  flags
);

    // Register roles per stage
    hazard_pkg::reg_role_t dd_role;
    hazard_pkg::reg_role_t exec_role;
    hazard_pkg::reg_role_t mem_role;
    hazard_pkg::reg_role_t wb_role;

    // Decode holds a store, used by load-use only
    logic dd_is_store;

    // Registered per path flags
    logic wb_dd_rs1;
    logic wb_dd_rs2;
    logic mem_exec_rs1;
    logic mem_exec_rs2;
    logic wb_exec_rs1;
    logic wb_exec_rs2;
    logic wb_mem_rs1;
    logic wb_mem_rs2;
    logic ld_use;

    assign dd_is_store = (dd_stage.opcode == hazard_pkg::op_st);

    // One decoder per stage
    operand_role_decode u_dd_decode (
        .stage (dd_stage),
        .role  (dd_role)
    );

    operand_role_decode u_exec_decode (
        .stage (exec_stage),
        .role  (exec_role)
    );

    operand_role_decode u_mem_decode (
        .stage (mem_stage),
        .role  (mem_role)
    );

    operand_role_decode u_wb_decode (
        .stage (wb_stage),
        .role  (wb_role)
    );

    // Writeback result into decode operand read
    fwd_path_compare u_wb_dd (
        .clk          (clk),
        .rst_n        (rst_n),
        .reader_valid (dd_stage.valid),
        .writer_valid (wb_stage.valid),
        .reader       (dd_role),
        .writer       (wb_role),
        .rs1_conflict (wb_dd_rs1),
        .rs2_conflict (wb_dd_rs2)
    );

    // Memory stage ALU result into execute
    // Load data not available here
    fwd_path_compare #(
        .load_writes (1'b0)
    ) u_mem_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .reader_valid (exec_stage.valid),
        .writer_valid (mem_stage.valid),
        .reader       (exec_role),
        .writer       (mem_role),
        .rs1_conflict (mem_exec_rs1),
        .rs2_conflict (mem_exec_rs2)
    );

    // Writeback into execute
    fwd_path_compare u_wb_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .reader_valid (exec_stage.valid),
        .writer_valid (wb_stage.valid),
        .reader       (exec_role),
        .writer       (wb_role),
        .rs1_conflict (wb_exec_rs1),
        .rs2_conflict (wb_exec_rs2)
    );

    // Writeback into memory, covers load then store
    fwd_path_compare u_wb_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .reader_valid (mem_stage.valid),
        .writer_valid (wb_stage.valid),
        .reader       (mem_role),
        .writer       (wb_role),
        .rs1_conflict (wb_mem_rs1),
        .rs2_conflict (wb_mem_rs2)
    );

    // Stall when decode needs a load still in execute
    load_use_detect u_load_use (
        .clk         (clk),
        .rst_n       (rst_n),
        .exec_valid  (exec_stage.valid),
        .dd_valid    (dd_stage.valid),
        .exec_role   (exec_role),
        .dd_role     (dd_role),
        .dd_is_store (dd_is_store),
        .ld_use      (ld_use)
    );

    // Collect into output struct, field order as in the package
    assign flags = '{
        wb_dd_rs1:    wb_dd_rs1,
        wb_dd_rs2:    wb_dd_rs2,
        mem_exec_rs1: mem_exec_rs1,
        mem_exec_rs2: mem_exec_rs2,
        wb_exec_rs1:  wb_exec_rs1,
        wb_exec_rs2:  wb_exec_rs2,
        wb_mem_rs1:   wb_mem_rs1,
        wb_mem_rs2:   wb_mem_rs2,
        ld_use:       ld_use
    };

endmodule

/* rtl/load_use_detect.sv */
module load_use_detect (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  exec_valid,
    input  logic                  dd_valid,
    input  hazard_pkg::reg_role_t exec_role,
    input  hazard_pkg::reg_role_t dd_role,
    input  logic                  dd_is_store,
    output logic                  ld_use
);

    // Load in execute with a real destination
    logic load_pending;
    logic src1_hit;
    logic src2_hit;
    logic stall;

    // Register 0 never carries a dependency
    assign load_pending = exec_valid && dd_valid && exec_role.is_load
                          && (exec_role.dest != '0);

    // Decode sources, zero register excluded
    assign src1_hit = dd_role.reads_src1 && (dd_role.src1 != '0)
                      && (dd_role.src1 == exec_role.dest);
    assign src2_hit = dd_role.reads_src2 && (dd_role.src2 != '0)
                      && (dd_role.src2 == exec_role.dest);

    // Load to store data is covered by wb to mem forwarding
    assign stall = load_pending && !dd_is_store && (src1_hit || src2_hit);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ld_use <= 1'b0;
        end
        else
        begin
            ld_use <= stall;
        end
    end

endmodule

/* rtl/fwd_path_compare.sv */
module fwd_path_compare #(
    // Clear to ignore load writers on this path
    parameter bit load_writes = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reader_valid,
    input  logic                  writer_valid,
    input  hazard_pkg::reg_role_t reader,
    input  hazard_pkg::reg_role_t writer,
    output logic                  rs1_conflict,
    output logic                  rs2_conflict
);

    // Writer result can be forwarded on this path
    logic dest_usable;
    logic rs1_hit;
    logic rs2_hit;

    // Both stages live and writer produces a register result
    // Load data is not ready yet when load_writes is clear
    assign dest_usable = reader_valid && writer_valid && writer.writes_dest
                         && (load_writes || !writer.is_load);

    // Per source match against the writer's dest
    assign rs1_hit = dest_usable && reader.reads_src1
                     && (reader.src1 == writer.dest);
    assign rs2_hit = dest_usable && reader.reads_src2
                     && (reader.src2 == writer.dest);

    // One cycle late flags
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rs1_conflict <= 1'b0;
            rs2_conflict <= 1'b0;
        end
        else
        begin
            rs1_conflict <= rs1_hit;
            rs2_conflict <= rs2_hit;
        end
    end

endmodule

/* rtl/operand_role_decode.sv */
module operand_role_decode (
    input  hazard_pkg::stage_info_t stage,
    output hazard_pkg::reg_role_t   role
);

    // Opcode classes
    logic no_src1;
    logic no_src2;
    logic no_dest;
    logic is_store;

    always_comb
    begin
        no_src1 = 1'b0;
        no_src2 = 1'b0;
        no_dest = 1'b0;
        case (stage.opcode)
            // Branches and nop touch no general register
            hazard_pkg::op_nop, hazard_pkg::op_b,
            hazard_pkg::op_beq, hazard_pkg::op_bgt:
            begin
                no_src1 = 1'b1;
                no_src2 = 1'b1;
                no_dest = 1'b1;
            end
            // Call only writes ra
            hazard_pkg::op_call:
            begin
                no_src1 = 1'b1;
                no_src2 = 1'b1;
            end
            // Unary ops take their input through op2
            hazard_pkg::op_not, hazard_pkg::op_mov:
                no_src1 = 1'b1;
            // Compare, store and ret produce no register result
            hazard_pkg::op_cmp, hazard_pkg::op_st, hazard_pkg::op_ret:
                no_dest = 1'b1;
            default:
                no_dest = 1'b0;
        endcase
    end

    assign is_store = (stage.opcode == hazard_pkg::op_st);

    // First source, ra for ret
    assign role.reads_src1 = !no_src1;
    assign role.src1       = (stage.opcode == hazard_pkg::op_ret) ? hazard_pkg::ra_index
                                                                  : stage.rs1;

    // Store data comes from rd, never from the immediate
    assign role.reads_src2 = !no_src2 && (is_store || !stage.imm_bit);
    // With imm_bit clear op2 holds an rs2 index
    assign role.src2       = is_store ? stage.rd : stage.op2.regs.rs2;

    // Destination, ra for call
    assign role.writes_dest = !no_dest;
    assign role.dest        = (stage.opcode == hazard_pkg::op_call) ? hazard_pkg::ra_index
                                                                    : stage.rd;

    assign role.is_load = (stage.opcode == hazard_pkg::op_ld);

endmodule

/* rtl/hazard_pkg.sv */
package hazard_pkg;

    // Register file index and instruction field widths
    localparam int reg_addr_width = 4;
    localparam int imm_width      = 18;
    localparam int opcode_width   = 5;

    // Return address register, implicit target of call and ret
    localparam logic [reg_addr_width-1:0] ra_index = 4'd15;

    // Upper bits of op2 when it carries a register index
    localparam int op2_pad_width = imm_width - reg_addr_width;

    // SimpleRisc opcode encoding
    typedef enum logic [opcode_width-1:0] {
        op_add  = 5'b00000,
        op_sub  = 5'b00001,
        op_mul  = 5'b00010,
        op_div  = 5'b00011,
        op_mod  = 5'b00100,
        op_cmp  = 5'b00101,
        op_and  = 5'b00110,
        op_or   = 5'b00111,
        op_not  = 5'b01000,
        op_mov  = 5'b01001,
        op_lsl  = 5'b01010,
        op_lsr  = 5'b01011,
        op_asr  = 5'b01100,
        op_nop  = 5'b01101,
        op_ld   = 5'b01110,
        op_st   = 5'b01111,
        op_beq  = 5'b10000,
        op_bgt  = 5'b10001,
        op_b    = 5'b10010,
        op_call = 5'b10011,
        op_ret  = 5'b10100
    } opcode_e;

    // Register view of the second operand
    typedef struct packed {
        logic [op2_pad_width-1:0]  pad;
        logic [reg_addr_width-1:0] rs2;
    } op2_regs_t;

    // Second operand, immediate or rs2 depending on imm_bit
    typedef union packed {
        logic [imm_width-1:0] imm;
        op2_regs_t            regs;
    } op2_u;

    // One pipeline stage as seen by the hazard logic
    typedef struct packed {
        logic                      valid;
        opcode_e                   opcode;
        logic                      imm_bit;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        op2_u                      op2;
    } stage_info_t;

    // Registers read and written by one stage
    typedef struct packed {
        logic                      reads_src1;
        logic [reg_addr_width-1:0] src1;
        logic                      reads_src2;
        logic [reg_addr_width-1:0] src2;
        logic                      writes_dest;
        logic [reg_addr_width-1:0] dest;
        // Load result only exists after memory access
        logic                      is_load;
    } reg_role_t;

    // Registered hazard flags
    typedef struct packed {
        // Writeback to decode
        logic wb_dd_rs1;
        logic wb_dd_rs2;
        // Memory to execute, loads excluded
        logic mem_exec_rs1;
        logic mem_exec_rs2;
        // Writeback to execute
        logic wb_exec_rs1;
        logic wb_exec_rs2;
        // Writeback to memory
        logic wb_mem_rs1;
        logic wb_mem_rs2;
        // Load in execute feeding decode
        logic ld_use;
    } fwd_flags_t;

endpackage
